// ==== rtl/tia_macros.svh ====
/*
 Timing and size constants of the video section
 Line, blank and sync positions in color clocks, playfield width
*/
`ifndef TIA_MACROS_SVH
`define TIA_MACROS_SVH

//////////////////////////////
// Horizontal line

`define TIA_LINE_CLOCKS   228 // Color clocks per line
`define TIA_STEP_CLOCKS   4   // One LFSR step every 4 clocks, 57 steps per line
`define TIA_LFSR_BITS     6

`define TIA_HBLANK_CLOCKS 68  // Clocks 0..67 blanked
`define TIA_HSYNC_START   16  // Hsync high on 16..31
`define TIA_HSYNC_END     32
`define TIA_CENTER_CLOCK  148 // First clock of the right half

//////////////////////////////
// Playfield

`define TIA_PF_BITS       20  // Bits per half line
`define TIA_PF_IDX_BITS   5   // Wide enough for 0..19

`endif

// ==== rtl/tia_pkg.sv ====
/*
 Shared types of the video section
 Write register addresses, horizontal events, color format
*/
package tia_pkg;

	//////////////////////////////
	// CPU write addresses kept in this design

	// Addresses as on the real chip, the gaps belonged to objects and audio
	typedef enum logic [5:0] {
		VSYNC  = 6'h00, // D1 vertical sync
		VBLANK = 6'h01, // D1 vertical blank
		WSYNC  = 6'h02, // Strobe, halt CPU until line start
		RSYNC  = 6'h03, // Strobe, restart line counter
		COLUPF = 6'h08, // D7..1 playfield color
		COLUBK = 6'h09, // D7..1 background color
		CTRLPF = 6'h0a, // D0 reflect
		PF0    = 6'h0d, // D7..4
		PF1    = 6'h0e, // D7..0, shown MSB first
		PF2    = 6'h0f  // D7..0, shown LSB first
	} write_reg_e;

	//////////////////////////////
	// Events decoded from the horizontal LFSR

	typedef enum logic [2:0] {
		ev_none,
		ev_line_start, // LFSR wrapped to zero
		ev_set_hsync,
		ev_rst_hsync,
		ev_rst_hblank, // Visible part begins
		ev_center,     // Right half begins
		ev_error       // All ones, lockup state
	} hevent_e;

	//////////////////////////////
	// Color register layout, bits 7..1 of COLUxx

	typedef struct packed {
		logic [3:0] hue;
		logic [2:0] lum;
	} color_t;

endpackage

// ==== rtl/video_regs_if.sv ====
/*
 Bundle of stored video registers
 Driven by the register file, read by the pixel path
*/
`include "tia_macros.svh"

interface video_regs_if;

	// Levels only, always valid, no handshake
	logic [`TIA_PF_BITS-1:0] pf;      // Display order, bit 0 is leftmost
	logic                    reflect; // Mirror the right half
	tia_pkg::color_t         colupf;
	tia_pkg::color_t         colubk;
	logic                    vsync;
	logic                    vblank;

	// Register file side
	modport source (
		output pf,
		output reflect,
		output colupf,
		output colubk,
		output vsync,
		output vblank
	);

	// Pixel path side
	// vsync only goes to the output pins, not into the pixel path
	modport sink (
		input pf,
		input reflect,
		input colupf,
		input colubk,
		input vblank
	);

endinterface

// ==== rtl/tia_regs.sv ====
/*
 CPU write port of the video registers
 Address decode, register storage, WSYNC and RSYNC strobes
*/
module tia_regs (
	input  logic              clk,
	input  logic              rst,
	input  logic              we,
	input  logic [5:0]        addr,
	input  logic [7:0]        d_in,
	video_regs_if.source      regs,
	output logic              wsync_stb,
	output logic              rsync_stb
);

	logic [3:0] pf0;     // Only D7..4 exist
	logic [7:0] pf1;
	logic [7:0] pf2;
	logic [7:0] pf1_rev; // PF1 in display order

	//////////////////////////////
	// Register storage

	always_ff @(posedge clk) begin
		if (rst) begin
			pf0         <= '0;
			pf1         <= '0;
			pf2         <= '0;
			regs.reflect <= 1'b0;
			regs.colupf <= '0;
			regs.colubk <= '0;
			regs.vsync  <= 1'b0;
			regs.vblank <= 1'b0;
		end else if (we) begin
			case (addr)
				tia_pkg::VSYNC:  regs.vsync  <= d_in[1];
				tia_pkg::VBLANK: regs.vblank <= d_in[1];
				tia_pkg::COLUPF: regs.colupf <= tia_pkg::color_t'(d_in[7:1]);
				tia_pkg::COLUBK: regs.colubk <= tia_pkg::color_t'(d_in[7:1]);
				tia_pkg::CTRLPF: regs.reflect <= d_in[0]; // Score and priority not kept
				tia_pkg::PF0:    pf0 <= d_in[7:4];
				tia_pkg::PF1:    pf1 <= d_in;
				tia_pkg::PF2:    pf2 <= d_in;
				default: ; // Strobes and unused addresses store nothing
			endcase
		end
	end

	//////////////////////////////
	// Strobes

	// One clock after the write, no storage behind them
	always_ff @(posedge clk) begin
		if (rst) begin
			wsync_stb <= 1'b0;
			rsync_stb <= 1'b0;
		end else begin
			wsync_stb <= we && (addr == tia_pkg::WSYNC);
			rsync_stb <= we && (addr == tia_pkg::RSYNC);
		end
	end

	//////////////////////////////
	// Playfield assembly

	// PF1 is drawn from D7 down to D0
	always_comb begin
		for (int i = 0; i < 8; i++) begin
			pf1_rev[i] = pf1[7 - i];
		end
	end

	// Bit 0 leftmost: PF0 D4..7, PF1 D7..0, PF2 D0..7
	assign regs.pf = {pf2, pf1_rev, pf0};

	//////////////////////////////
	// Checks

	// CPU writes are a CPU cycle apart at least, so a strobe is one clock
	// wide and the line counter and rdy logic see each write once
	a_wsync_single: assert property (@(posedge clk) disable iff (rst)
		wsync_stb |=> !wsync_stb)
		else $error("wsync_stb high for two clocks");

	a_rsync_single: assert property (@(posedge clk) disable iff (rst)
		rsync_stb |=> !rsync_stb)
		else $error("rsync_stb high for two clocks");

endmodule

// ==== rtl/horiz_timing.sv ====
/*
 Horizontal timing of one line
 Clock divider, 6-bit LFSR step counter, event decode
 Registered hsync, hblank, center and rdy
*/
`include "tia_macros.svh"

module horiz_timing (
	input  logic clk,
	input  logic rst,
	input  logic rsync_stb, // Restart line, next clock is line clock 0
	input  logic wsync_stb, // Halt CPU until next line start
	output logic hsync,
	output logic hblank,
	output logic center,    // High for the right half of the line
	output logic line_start, // Last clock of a line, next one is line clock 0
	output logic rdy
);

	//////////////////////////////
	// LFSR helpers

	// XNOR of the two low bits shifted in from the top
	function automatic logic [`TIA_LFSR_BITS-1:0] lfsr_step(
		input logic [`TIA_LFSR_BITS-1:0] s
	);
		return {~(s[1] ^ s[0]), s[`TIA_LFSR_BITS-1:1]};
	endfunction

	// State reached after n steps from zero
	function automatic logic [`TIA_LFSR_BITS-1:0] lfsr_at(input int n);
		logic [`TIA_LFSR_BITS-1:0] s;
		s = '0;
		for (int i = 0; i < n; i++) begin
			s = lfsr_step(s);
		end
		return s;
	endfunction

	// Step  0 000000, 4 111100, 8 110111, 17 101110, 37 110110, 56 010100
	localparam logic [`TIA_LFSR_BITS-1:0] st_start      = lfsr_at(0);
	localparam logic [`TIA_LFSR_BITS-1:0] st_set_hsync  =
		lfsr_at(`TIA_HSYNC_START / `TIA_STEP_CLOCKS);
	localparam logic [`TIA_LFSR_BITS-1:0] st_rst_hsync  =
		lfsr_at(`TIA_HSYNC_END / `TIA_STEP_CLOCKS);
	localparam logic [`TIA_LFSR_BITS-1:0] st_rst_hblank =
		lfsr_at(`TIA_HBLANK_CLOCKS / `TIA_STEP_CLOCKS);
	localparam logic [`TIA_LFSR_BITS-1:0] st_center     =
		lfsr_at(`TIA_CENTER_CLOCK / `TIA_STEP_CLOCKS);
	localparam logic [`TIA_LFSR_BITS-1:0] st_last       =
		lfsr_at(`TIA_LINE_CLOCKS / `TIA_STEP_CLOCKS - 1);
	localparam logic [`TIA_LFSR_BITS-1:0] st_error      = '1; // Maps onto itself

	logic [1:0]                div;      // Clock within step
	logic                      step;     // Last clock of a step
	logic [`TIA_LFSR_BITS-1:0] lfsr;     // Step counter
	logic [`TIA_LFSR_BITS-1:0] lfsr_nxt;
	tia_pkg::hevent_e          hev;

	assign step = (div == 2'(`TIA_STEP_CLOCKS - 1));

	// Wrap after the last step of the line
	assign lfsr_nxt = (lfsr == st_last) ? st_start : lfsr_step(lfsr);

	//////////////////////////////
	// Event decode

	// Events describe the step about to begin
	always_comb begin
		hev = tia_pkg::ev_none;
		if (step) begin
			case (lfsr_nxt)
				st_start:      hev = tia_pkg::ev_line_start;
				st_set_hsync:  hev = tia_pkg::ev_set_hsync;
				st_rst_hsync:  hev = tia_pkg::ev_rst_hsync;
				st_rst_hblank: hev = tia_pkg::ev_rst_hblank;
				st_center:     hev = tia_pkg::ev_center;
				st_error:      hev = tia_pkg::ev_error;
				default:       hev = tia_pkg::ev_none;
			endcase
		end
	end

	// An error restart counts as a new line too
	assign line_start = rsync_stb || (hev == tia_pkg::ev_line_start) ||
		(hev == tia_pkg::ev_error);

	//////////////////////////////
	// Counter and registered outputs

	always_ff @(posedge clk) begin
		if (rst || rsync_stb) begin // Next clock is line clock 0
			div    <= '0;
			lfsr   <= st_start;
			hsync  <= 1'b0;
			hblank <= 1'b1;
			center <= 1'b0;
			rdy    <= 1'b1;
		end else begin
			div <= div + 2'd1;
			if (wsync_stb)
				rdy <= 1'b0; // CPU waits for the next line
			if (step) begin
				lfsr <= (hev == tia_pkg::ev_error) ? st_start : lfsr_nxt;
				case (hev)
					tia_pkg::ev_line_start, tia_pkg::ev_error: begin
						hsync  <= 1'b0;
						hblank <= 1'b1;
						center <= 1'b0;
						rdy    <= 1'b1; // Wins over a late WSYNC
					end
					tia_pkg::ev_set_hsync:  hsync  <= 1'b1;
					tia_pkg::ev_rst_hsync:  hsync  <= 1'b0;
					tia_pkg::ev_rst_hblank: hblank <= 1'b0;
					tia_pkg::ev_center:     center <= 1'b1;
					default: ;
				endcase
			end
		end
	end

	//////////////////////////////
	// Checks

	// All ones is unreachable from zero, seeing it means corrupted state
	a_lfsr_no_lockup: assert property (@(posedge clk) disable iff (rst)
		lfsr != st_error)
		else $error("horizontal LFSR in lockup state");

endmodule

// ==== rtl/playfield_pixel.sv ====
/*
 Playfield pixel path
 Bit index sequencing with reflect, color select, blanking
*/
`include "tia_macros.svh"

module playfield_pixel (
	input  logic         clk,
	input  logic         rst,
	video_regs_if.sink   regs,
	input  logic         hblank,
	input  logic         center,     // Right half of the line
	input  logic         line_start, // Last clock of the line
	output logic [3:0]   col,
	output logic [2:0]   lum
);

	localparam logic [`TIA_PF_IDX_BITS-1:0] last_idx = `TIA_PF_IDX_BITS'(`TIA_PF_BITS - 1);

	logic [1:0]                  sub;  // Clock within one playfield bit
	logic [`TIA_PF_IDX_BITS-1:0] idx;  // Playfield bit shown next
	logic                        dir;  // 1 counts down, mirrored right half
	logic                        pf_bit;
	tia_pkg::color_t             pix;

	//////////////////////////////
	// Bit index

	// Held at bit 0 through blanking, so line clock 68 starts the left half
	always_ff @(posedge clk) begin
		if (rst || line_start || hblank) begin
			sub <= '0;
			idx <= '0;
			dir <= 1'b0;
		end else begin
			sub <= sub + 2'd1;
			if (sub == 2'd3) begin // Four clocks per bit
				if (!center && !dir && idx == last_idx) begin
					// End of left half
					if (regs.reflect)
						dir <= 1'b1; // Repeat bit 19, then walk back
					else
						idx <= '0;   // Same order again
				end else if (dir) begin
					if (idx != '0)
						idx <= idx - 1'b1;
				end else if (idx != last_idx) begin
					idx <= idx + 1'b1;
				end
			end
		end
	end

	assign pf_bit = regs.pf[idx];

	//////////////////////////////
	// Color select

	// Zero covers line clocks 0..68 and vertical blank
	always_ff @(posedge clk) begin
		if (rst)
			pix <= '0;
		else if (hblank || line_start || regs.vblank)
			pix <= '0;
		else
			pix <= pf_bit ? regs.colupf : regs.colubk; // Background shows through
	end

	assign col = pix.hue;
	assign lum = pix.lum;

	//////////////////////////////
	// Checks

	// Index must stay inside the 20 playfield bits over the whole line
	a_idx_range: assert property (@(posedge clk) disable iff (rst)
		idx < `TIA_PF_BITS)
		else $error("playfield index out of range");

endmodule

// ==== rtl/tia_video.sv ====
/*
 Video section top level
 Register file, horizontal timing and playfield pixel path
*/
module tia_video (
	input  logic       clk,
	input  logic       rst,
	input  logic       we,     // CPU write
	input  logic [5:0] addr,
	input  logic [7:0] d_in,
	output logic       rdy,    // Low while waiting on WSYNC
	output logic       hsync,
	output logic       hblank,
	output logic       vsync,
	output logic       vblank,
	output logic       blk_n,
	output logic       sync_n,
	output logic [3:0] col,
	output logic [2:0] lum
);

	logic wsync_stb;
	logic rsync_stb;
	logic line_start;
	logic center;

	video_regs_if vregs ();

	tia_regs tia_regs_i (
		.clk       (clk),
		.rst       (rst),
		.we        (we),
		.addr      (addr),
		.d_in      (d_in),
		.regs      (vregs.source),
		.wsync_stb (wsync_stb),
		.rsync_stb (rsync_stb)
	);

	horiz_timing horiz_timing_i (
		.clk        (clk),
		.rst        (rst),
		.rsync_stb  (rsync_stb),
		.wsync_stb  (wsync_stb),
		.hsync      (hsync),
		.hblank     (hblank),
		.center     (center),
		.line_start (line_start),
		.rdy        (rdy)
	);

	playfield_pixel playfield_pixel_i (
		.clk        (clk),
		.rst        (rst),
		.regs       (vregs.sink),
		.hblank     (hblank),
		.center     (center),
		.line_start (line_start),
		.col        (col),
		.lum        (lum)
	);

	// Vertical timing comes straight from the CPU registers
	assign vsync  = vregs.vsync;
	assign vblank = vregs.vblank;

	// Composite blank and sync, active low
	assign blk_n  = ~(hblank | vregs.vblank);
	assign sync_n = ~(hsync | vregs.vsync);

endmodule

// ==== verification/tia_video_model.svh ====
/*
 Reference model of the video outputs
 Line clock and rdy tracking, hsync and hblank windows, playfield pixel
*/
`ifndef TIA_VIDEO_MODEL_SVH
`define TIA_VIDEO_MODEL_SVH

`include "tia_macros.svh"

localparam int pf_bit_clocks = 4; // Color clocks per playfield bit

// Restart after an RSYNC strobe cycle, else count and wrap
function automatic int advance_line_clock(input int c, input logic restart);
	if (restart)
		return 0;
	return (c + 1) % `TIA_LINE_CLOCKS;
endfunction

// Line start releases the CPU, even over a WSYNC in the same clock
function automatic logic update_rdy(input logic r, input int c,
	input logic wsync_cycle, input logic rsync_cycle);
	if (rsync_cycle || c == `TIA_LINE_CLOCKS - 1)
		return 1'b1;
	if (wsync_cycle)
		return 1'b0;
	return r;
endfunction

function automatic logic expected_hsync(input int c);
	return (c >= `TIA_HSYNC_START) && (c < `TIA_HSYNC_END);
endfunction

function automatic logic expected_hblank(input int c);
	return c < `TIA_HBLANK_CLOCKS;
endfunction

// Bit b of the playfield, counted from the left edge
function automatic logic playfield_bit(input logic [7:0] pf0, input logic [7:0] pf1,
	input logic [7:0] pf2, input int b);
	if (b < 4)
		return pf0[4 + b];  // PF0 D4 first
	if (b < 12)
		return pf1[11 - b]; // PF1 D7 first
	return pf2[b - 12];     // PF2 D0 first
endfunction

// Returns {hue, lum}
function automatic logic [6:0] expected_pixel(input int c, input logic [7:0] pf0,
	input logic [7:0] pf1, input logic [7:0] pf2, input logic [7:0] ctrlpf,
	input logic [7:0] colupf, input logic [7:0] colubk, input logic vblank);
	int pos;
	int k;
	int b;
	if (c <= `TIA_HBLANK_CLOCKS || vblank)
		return 7'd0; // Blanked, plus the pipeline clock at 68
	pos = c - `TIA_HBLANK_CLOCKS - 1;
	k = pos / pf_bit_clocks;
	if (k < `TIA_PF_BITS)
		b = k;
	else if (ctrlpf[0])
		b = 2 * `TIA_PF_BITS - 1 - k; // Mirrored right half
	else
		b = k - `TIA_PF_BITS;
	return playfield_bit(pf0, pf1, pf2, b) ? colupf[7:1] : colubk[7:1];
endfunction

`endif

// ==== verification/tia_video_tb.sv ====
/*
 Testbench of the video section
 Clock, reset, register stimulus, per-clock compare against the model
*/
`include "tia_macros.svh"

module tia_video_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int clk_period = 20;
	localparam int watchdog_clocks = 42 * `TIA_LINE_CLOCKS; // 40 lines, 2 spare

	logic       clk;
	logic       rst;
	logic       we;
	logic [5:0] addr;
	logic [7:0] d_in;
	logic       rdy;
	logic       hsync;
	logic       hblank;
	logic       vsync;
	logic       vblank;
	logic       blk_n;
	logic       sync_n;
	logic [3:0] col;
	logic [2:0] lum;

	// Model state, updated on each rising edge
	int         lc;         // Line clock of the current cycle
	logic       rdy_m;
	logic       wsync_cyc;  // Current cycle is a WSYNC strobe cycle
	logic       rsync_cyc;
	logic [7:0] pf0_s;
	logic [7:0] pf1_s;
	logic [7:0] pf2_s;
	logic [7:0] ctrlpf_s;
	logic [7:0] colupf_s;
	logic [7:0] colubk_s;
	logic       vsync_s;
	logic       vblank_s;
	bit         model_valid = 1'b0;
	int         errors = 0;
	int         checks = 0;
	integer     seed;

	`include "tia_video_model.svh"

	tia_video tia_video_i (
		.clk    (clk),
		.rst    (rst),
		.we     (we),
		.addr   (addr),
		.d_in   (d_in),
		.rdy    (rdy),
		.hsync  (hsync),
		.hblank (hblank),
		.vsync  (vsync),
		.vblank (vblank),
		.blk_n  (blk_n),
		.sync_n (sync_n),
		.col    (col),
		.lum    (lum)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	//////////////////////////////
	// Helpers

	task automatic report_mismatch(input string name, input logic [7:0] expected,
		input logic [7:0] actual);
		errors++;
		$display("error at %0t: %s expected %h actual %h", $time, name, expected, actual);
	endtask

	function automatic logic [7:0] random_byte();
		logic [31:0] r;
		r = $random(seed);
		return r[7:0];
	endfunction

	task automatic step_clock();
		@(posedge clk);
		#2;
	endtask

	task automatic wait_line_clock(input int target);
		while (lc != target)
			step_clock();
	endtask

	task automatic run_lines(input int n);
		repeat (n * `TIA_LINE_CLOCKS) step_clock();
	endtask

	// Sampled at the end of the current cycle
	task automatic write_reg(input tia_pkg::write_reg_e a, input logic [7:0] d);
		we   = 1'b1;
		addr = a;
		d_in = d;
		step_clock();
		we   = 1'b0;
		addr = '0;
		d_in = '0;
	endtask

	// Early in hblank, well before the first visible pixel
	task automatic load_playfield(input logic reflect);
		logic [7:0] ctrl;
		wait_line_clock(1);
		ctrl = random_byte(); // Score and priority bits ride along
		ctrl[0] = reflect;
		write_reg(tia_pkg::PF0, random_byte());
		write_reg(tia_pkg::PF1, random_byte());
		write_reg(tia_pkg::PF2, random_byte());
		write_reg(tia_pkg::COLUPF, random_byte());
		write_reg(tia_pkg::COLUBK, random_byte());
		write_reg(tia_pkg::CTRLPF, ctrl);
	endtask

	//////////////////////////////
	// Model tracking

	always @(posedge clk) begin : track_model
		if (rst) begin
			lc = 0;
			rdy_m = 1'b1;
			wsync_cyc = 1'b0;
			rsync_cyc = 1'b0;
			pf0_s = '0;
			pf1_s = '0;
			pf2_s = '0;
			ctrlpf_s = '0;
			colupf_s = '0;
			colubk_s = '0;
			vsync_s = 1'b0;
			vblank_s = 1'b0;
			model_valid = 1'b1; // DUT outputs defined from here on
		end else begin
			rdy_m = update_rdy(rdy_m, lc, wsync_cyc, rsync_cyc);
			lc = advance_line_clock(lc, rsync_cyc);
			wsync_cyc = we && (addr == tia_pkg::WSYNC);
			rsync_cyc = we && (addr == tia_pkg::RSYNC);
			if (we) begin
				case (addr)
					tia_pkg::VSYNC:  vsync_s = d_in[1];
					tia_pkg::VBLANK: vblank_s = d_in[1];
					tia_pkg::COLUPF: colupf_s = d_in;
					tia_pkg::COLUBK: colubk_s = d_in;
					tia_pkg::CTRLPF: ctrlpf_s = d_in;
					tia_pkg::PF0:    pf0_s = d_in;
					tia_pkg::PF1:    pf1_s = d_in;
					tia_pkg::PF2:    pf2_s = d_in;
					default: ;
				endcase
			end
		end
	end

	//////////////////////////////
	// Compare, mid-cycle where outputs are settled

	always @(negedge clk) begin : compare
		logic [6:0] exp_pix;
		logic       exp_hs;
		logic       exp_hb;
		logic       exp_blk_n;
		logic       exp_sync_n;
		if (model_valid) begin
			exp_hs = expected_hsync(lc);
			exp_hb = expected_hblank(lc);
			exp_blk_n = ~(exp_hb | vblank_s);
			exp_sync_n = ~(exp_hs | vsync_s);
			exp_pix = expected_pixel(lc, pf0_s, pf1_s, pf2_s, ctrlpf_s, colupf_s,
				colubk_s, vblank_s);
			checks++;
			if (hsync !== exp_hs)
				report_mismatch("hsync", exp_hs, hsync);
			if (hblank !== exp_hb)
				report_mismatch("hblank", exp_hb, hblank);
			if (rdy !== rdy_m)
				report_mismatch("rdy", rdy_m, rdy);
			if (vsync !== vsync_s)
				report_mismatch("vsync", vsync_s, vsync);
			if (vblank !== vblank_s)
				report_mismatch("vblank", vblank_s, vblank);
			if (blk_n !== exp_blk_n)
				report_mismatch("blk_n", exp_blk_n, blk_n);
			if (sync_n !== exp_sync_n)
				report_mismatch("sync_n", exp_sync_n, sync_n);
			if (col !== exp_pix[6:3])
				report_mismatch("col", exp_pix[6:3], col);
			if (lum !== exp_pix[2:0])
				report_mismatch("lum", exp_pix[2:0], lum);
		end
	end

	//////////////////////////////
	// Stimulus

	initial begin : stimulus
		int n;
		seed = 32'h2c4e;
		rst  = 1'b1;
		we   = 1'b0;
		addr = '0;
		d_in = '0;
		repeat (2) @(posedge clk);
		#2 rst = 1'b0;

		// Reset state, then free-running lines
		if (rdy !== 1'b1)
			report_mismatch("rdy after reset", 1, rdy);
		if (hblank !== 1'b1)
			report_mismatch("hblank after reset", 1, hblank);
		run_lines(3);

		// Line restart in mid line
		wait_line_clock(100);
		write_reg(tia_pkg::RSYNC, 8'h00); // Returns in the strobe cycle
		step_clock();                     // Line clock 0
		n = 0;
		while (hsync !== 1'b1 && n < `TIA_LINE_CLOCKS) begin
			step_clock();
			n++;
		end
		if (n != `TIA_HSYNC_START)
			report_mismatch("hsync delay after RSYNC", `TIA_HSYNC_START, n);
		run_lines(1);

		// Background only
		wait_line_clock(1);
		write_reg(tia_pkg::PF0, 8'h00);
		write_reg(tia_pkg::PF1, 8'h00);
		write_reg(tia_pkg::PF2, 8'h00);
		write_reg(tia_pkg::CTRLPF, 8'h00);
		write_reg(tia_pkg::COLUBK, random_byte());
		run_lines(2);

		// Random playfield, repeated then mirrored
		repeat (4) begin
			load_playfield(1'b0);
			wait_line_clock(`TIA_LINE_CLOCKS - 1);
		end
		repeat (4) begin
			load_playfield(1'b1);
			wait_line_clock(`TIA_LINE_CLOCKS - 1);
		end

		// CPU halt until line start
		wait_line_clock(10);
		write_reg(tia_pkg::WSYNC, random_byte());
		step_clock();
		if (rdy !== 1'b0)
			report_mismatch("rdy after WSYNC", 0, rdy);
		n = 0;
		while (rdy !== 1'b1 && n < 2 * `TIA_LINE_CLOCKS) begin
			step_clock();
			n++;
		end
		if (rdy !== 1'b1) begin
			errors++;
			$display("rdy never returned high after the WSYNC write");
		end else if (lc != 0)
			report_mismatch("line clock at rdy release", 0, lc);

		// Vertical blank and sync
		wait_line_clock(1);
		write_reg(tia_pkg::VBLANK, 8'h02);
		wait_line_clock(100);
		if (blk_n !== 1'b0)
			report_mismatch("blk_n during VBLANK", 0, blk_n);
		wait_line_clock(1);
		write_reg(tia_pkg::VBLANK, 8'h00);
		write_reg(tia_pkg::VSYNC, 8'h02);
		wait_line_clock(100);
		if (sync_n !== 1'b0)
			report_mismatch("sync_n during VSYNC", 0, sync_n);
		wait_line_clock(1);
		write_reg(tia_pkg::VSYNC, 8'h00);
		run_lines(1);

		$display("clocks compared %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

	//////////////////////////////
	// Watchdog

	initial begin
		#(watchdog_clocks * clk_period);
		$display("timeout, run still busy after %0d clocks", watchdog_clocks);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// ==== sources.f ====
+incdir+rtl
+incdir+verification
rtl/tia_pkg.sv
rtl/video_regs_if.sv
rtl/tia_regs.sv
rtl/horiz_timing.sv
rtl/playfield_pixel.sv
rtl/tia_video.sv
verification/tia_video_tb.sv
